/* design/muldiv_settings.svh */
`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// ==========================================================
// Datapath
// ==========================================================

`define XLEN 32

// Multiplier bits consumed by each pipeline stage
`define MUL_UNROLL 8

// ==========================================================
// Scheduler side
// ==========================================================

`define RNID_W 6
`define RV_ENTRY_SIZE 8   // Issue slots, one-hot
`define BR_MASK_W 4       // Outstanding branch tags

`endif

/* design/muldiv_pkg.sv */
`default_nettype none

`include "muldiv_settings.svh"

package muldiv_pkg;

  // ==========================================================
  // Widths
  // ==========================================================

  typedef logic [`XLEN-1:0]          xlen_t;
  typedef logic [`RNID_W-1:0]        rnid_t;
  typedef logic [`RV_ENTRY_SIZE-1:0] index_oh_t;   // Issue slot, one-hot
  typedef logic [`BR_MASK_W-1:0]     br_mask_t;

  // ==========================================================
  // Operations
  // ==========================================================

  typedef enum logic [3:0] {
    OP_NONE,
    OP_MUL,
    OP_MULH,
    OP_MULHU,
    OP_MULHSU,
    OP_DIV,
    OP_DIVU,
    OP_REM,
    OP_REMU
  } op_t;

  // Destination identity returned with the result
  typedef struct packed {
    rnid_t     rd_rnid;
    index_oh_t index_oh;
  } tag_t;

  typedef struct packed {
    op_t      op;
    xlen_t    rs1;   // Dividend
    xlen_t    rs2;   // Divisor
    tag_t     tag;
    br_mask_t br_mask;
  } div_req_t;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_BUSY,
    DIV_DONE   // Result held for the response port
  } div_state_t;

endpackage

`default_nettype wire

/* design/mul_step_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_settings.svh"

module mul_step_pipe (
  input  wire                    i_clk,
  input  wire                    i_reset_n,

  input  wire                    i_valid,
  input  wire muldiv_pkg::op_t   i_op,
  input  wire muldiv_pkg::xlen_t i_rs1,
  input  wire muldiv_pkg::xlen_t i_rs2,
  input  wire muldiv_pkg::tag_t  i_tag,

  output logic                   o_valid,
  output muldiv_pkg::xlen_t      o_res,
  output muldiv_pkg::tag_t       o_tag
);

  localparam int XLEN     = `XLEN;
  localparam int UNROLL   = `MUL_UNROLL;
  localparam int MUL_STEP = (XLEN + UNROLL - 1) / UNROLL;
  localparam int MUL_W    = MUL_STEP * UNROLL;    // Multiplier bits covered by all slices
  localparam int PROD_W   = XLEN + MUL_W + 2;

  typedef struct packed {
    muldiv_pkg::op_t   op;
    muldiv_pkg::tag_t  tag;
    logic [XLEN:0]     mcand;   // rs1, one bit wider
    logic [MUL_W:0]    mplr;    // rs2, sliced per stage
    logic [PROD_W-1:0] prod;
  } mul_stage_t;

  // ==========================================================
  // Operand extension
  // ==========================================================

  logic       w_mcand_signed;
  logic       w_mplr_signed;
  mul_stage_t w_head;

  assign w_mcand_signed = (i_op == muldiv_pkg::OP_MUL) |
                          (i_op == muldiv_pkg::OP_MULH) |
                          (i_op == muldiv_pkg::OP_MULHSU);
  assign w_mplr_signed  = (i_op == muldiv_pkg::OP_MUL) |
                          (i_op == muldiv_pkg::OP_MULH);

  always_comb begin
    w_head.op    = i_op;
    w_head.tag   = i_tag;
    w_head.mcand = {w_mcand_signed & i_rs1[XLEN-1], i_rs1};
    w_head.mplr  = {{(MUL_W + 1 - XLEN){w_mplr_signed & i_rs2[XLEN-1]}}, i_rs2};
    w_head.prod  = '0;
  end

  // ==========================================================
  // Stages
  // ==========================================================

  logic       r_valid [MUL_STEP];
  mul_stage_t r_stage [MUL_STEP];

  generate
    for (genvar s = 0; s < MUL_STEP; s++) begin : g_step
      mul_stage_t               w_in;
      mul_stage_t               w_out;
      logic                     w_in_valid;
      logic [UNROLL:0]          w_slice;
      logic signed [PROD_W-1:0] w_pp;

      if (s == 0) begin : g_first
        assign w_in       = w_head;
        assign w_in_valid = i_valid;
      end else begin : g_next
        assign w_in       = r_stage[s-1];
        assign w_in_valid = r_valid[s-1];
      end

      // Only the top slice holds the sign of rs2
      if (s == MUL_STEP - 1) begin : g_top_slice
        assign w_slice = w_in.mplr[s*UNROLL +: UNROLL+1];
      end else begin : g_low_slice
        assign w_slice = {1'b0, w_in.mplr[s*UNROLL +: UNROLL]};
      end

      assign w_pp = PROD_W'($signed(w_in.mcand)) * PROD_W'($signed(w_slice));

      always_comb begin
        w_out      = w_in;
        w_out.prod = w_in.prod + (w_pp <<< (s * UNROLL));   // Weight of this slice
      end

      always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
          r_valid[s] <= 1'b0;
        end else begin
          r_valid[s] <= w_in_valid;
        end
      end

      always_ff @(posedge i_clk) begin
        r_stage[s] <= w_out;
      end
    end
  endgenerate

  // ==========================================================
  // Result word
  // ==========================================================

  mul_stage_t w_tail;

  assign w_tail  = r_stage[MUL_STEP-1];

  assign o_valid = r_valid[MUL_STEP-1];
  assign o_tag   = w_tail.tag;
  assign o_res   = (w_tail.op == muldiv_pkg::OP_MUL) ? w_tail.prod[XLEN-1:0] :
                                                       w_tail.prod[XLEN +: XLEN];   // MULH forms

endmodule

`default_nettype wire

/* design/div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_settings.svh"

module div_unit (
  input  wire                         i_clk,
  input  wire                         i_reset_n,

  input  wire                         i_valid,
  input  wire muldiv_pkg::div_req_t   i_req,
  output logic                        o_ready,

  input  wire                         i_kill_valid,
  input  wire muldiv_pkg::br_mask_t   i_kill_mask,
  input  wire                         i_flush,

  input  wire                         i_resp_ready,
  output logic                        o_valid,
  output muldiv_pkg::xlen_t           o_res,
  output muldiv_pkg::tag_t            o_tag
);

  localparam int XLEN  = `XLEN;
  localparam int CNT_W = $clog2(XLEN + 1);

  muldiv_pkg::div_state_t r_state;
  muldiv_pkg::div_req_t   r_req;
  logic [CNT_W-1:0]       r_count;
  muldiv_pkg::xlen_t      r_dvsr;    // |divisor|
  muldiv_pkg::xlen_t      r_quo;     // Dividend shifts out, quotient shifts in
  logic signed [XLEN:0]   r_rem;
  muldiv_pkg::xlen_t      r_res;

  // ==========================================================
  // Request decode
  // ==========================================================

  logic              w_start;
  logic              w_req_signed;
  logic              w_req_rem;
  logic              w_div_zero;
  logic              w_overflow;
  muldiv_pkg::xlen_t w_abs_rs1;
  muldiv_pkg::xlen_t w_abs_rs2;
  muldiv_pkg::xlen_t w_special_res;

  assign w_start      = i_valid & (r_state == muldiv_pkg::DIV_IDLE);
  assign w_req_signed = (i_req.op == muldiv_pkg::OP_DIV) | (i_req.op == muldiv_pkg::OP_REM);
  assign w_req_rem    = (i_req.op == muldiv_pkg::OP_REM) | (i_req.op == muldiv_pkg::OP_REMU);
  assign w_div_zero   = (i_req.rs2 == '0);
  assign w_overflow   = w_req_signed & (i_req.rs1 == {1'b1, {(XLEN-1){1'b0}}}) & (&i_req.rs2);

  assign w_abs_rs1 = (w_req_signed & i_req.rs1[XLEN-1]) ? -i_req.rs1 : i_req.rs1;
  assign w_abs_rs2 = (w_req_signed & i_req.rs2[XLEN-1]) ? -i_req.rs2 : i_req.rs2;

  always_comb begin
    if (w_div_zero) begin
      w_special_res = w_req_rem ? i_req.rs1 : '1;
    end else begin
      w_special_res = w_req_rem ? '0 : i_req.rs1;   // Most negative / -1
    end
  end

  // ==========================================================
  // Iteration and fix-up
  // ==========================================================

  logic                   w_last;
  logic signed [XLEN+1:0] w_shift;
  logic signed [XLEN+1:0] w_step;
  logic [XLEN:0]          w_rem_fix;
  logic                   w_signed;
  logic                   w_neg_q;
  logic                   w_neg_r;
  muldiv_pkg::xlen_t      w_quo_res;
  muldiv_pkg::xlen_t      w_rem_res;
  logic                   w_squash;

  assign w_last  = (r_count == CNT_W'(XLEN));
  assign w_shift = {r_rem, r_quo[XLEN-1]};
  assign w_step  = r_rem[XLEN] ? w_shift + {2'b00, r_dvsr} :   // Negative remainder adds back
                                 w_shift - {2'b00, r_dvsr};

  assign w_rem_fix = r_rem[XLEN] ? r_rem + {1'b0, r_dvsr} : r_rem;

  assign w_signed  = (r_req.op == muldiv_pkg::OP_DIV) | (r_req.op == muldiv_pkg::OP_REM);
  assign w_neg_q   = w_signed & (r_req.rs1[XLEN-1] ^ r_req.rs2[XLEN-1]);
  assign w_neg_r   = w_signed & r_req.rs1[XLEN-1];   // Remainder takes the dividend sign
  assign w_quo_res = w_neg_q ? -r_quo : r_quo;
  assign w_rem_res = w_neg_r ? -w_rem_fix[XLEN-1:0] : w_rem_fix[XLEN-1:0];

  assign w_squash = i_flush | (i_kill_valid & (|(i_kill_mask & r_req.br_mask)));

  // ==========================================================
  // Control
  // ==========================================================

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= muldiv_pkg::DIV_IDLE;
      r_count <= '0;
    end else begin
      case (r_state)
        muldiv_pkg::DIV_IDLE: begin
          r_count <= '0;
          if (w_start) begin
            r_state <= (w_div_zero | w_overflow) ? muldiv_pkg::DIV_DONE : muldiv_pkg::DIV_BUSY;
          end
        end
        muldiv_pkg::DIV_BUSY: begin
          if (w_squash) begin
            r_state <= muldiv_pkg::DIV_IDLE;
          end else if (w_last) begin
            r_state <= muldiv_pkg::DIV_DONE;
          end else begin
            r_count <= r_count + 1'b1;
          end
        end
        muldiv_pkg::DIV_DONE: begin
          if (w_squash | i_resp_ready) begin
            r_state <= muldiv_pkg::DIV_IDLE;
          end
        end
        default: r_state <= muldiv_pkg::DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_start) begin
      r_req  <= i_req;
      r_quo  <= w_abs_rs1;
      r_dvsr <= w_abs_rs2;
      r_rem  <= '0;
      r_res  <= w_special_res;
    end else if (r_state == muldiv_pkg::DIV_BUSY) begin
      if (w_last) begin
        r_res <= (r_req.op == muldiv_pkg::OP_REM || r_req.op == muldiv_pkg::OP_REMU) ?
                 w_rem_res : w_quo_res;
      end else begin
        r_rem <= w_step[XLEN:0];
        r_quo <= {r_quo[XLEN-2:0], ~w_step[XLEN+1]};   // One quotient bit per cycle
      end
    end
  end

  assign o_ready = (r_state == muldiv_pkg::DIV_IDLE);
  assign o_valid = (r_state == muldiv_pkg::DIV_DONE) & ~w_squash;
  assign o_res   = r_res;
  assign o_tag   = r_req.tag;

endmodule

`default_nettype wire

/* design/muldiv_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_pipe (
  input  wire                       i_clk,
  input  wire                       i_reset_n,

  input  wire                       i_valid,
  input  wire muldiv_pkg::op_t      i_op,
  input  wire muldiv_pkg::xlen_t    i_rs1,
  input  wire muldiv_pkg::xlen_t    i_rs2,
  input  wire muldiv_pkg::tag_t     i_tag,
  input  wire muldiv_pkg::br_mask_t i_br_mask,

  input  wire                       i_br_kill_valid,
  input  wire muldiv_pkg::br_mask_t i_br_kill_mask,
  input  wire                       i_flush,

  output logic                      o_stall,

  output logic                      o_valid,
  output muldiv_pkg::xlen_t         o_res,
  output muldiv_pkg::tag_t          o_tag
);

  // ==========================================================
  // Decode
  // ==========================================================

  logic                 w_is_mul;
  logic                 w_is_div;
  muldiv_pkg::div_req_t w_div_req;

  assign w_is_mul = (i_op == muldiv_pkg::OP_MUL)   | (i_op == muldiv_pkg::OP_MULH) |
                    (i_op == muldiv_pkg::OP_MULHU) | (i_op == muldiv_pkg::OP_MULHSU);
  assign w_is_div = (i_op == muldiv_pkg::OP_DIV)   | (i_op == muldiv_pkg::OP_DIVU) |
                    (i_op == muldiv_pkg::OP_REM)   | (i_op == muldiv_pkg::OP_REMU);

  always_comb begin
    w_div_req.op      = i_op;
    w_div_req.rs1     = i_rs1;
    w_div_req.rs2     = i_rs2;
    w_div_req.tag     = i_tag;
    w_div_req.br_mask = i_br_mask;
  end

  // ==========================================================
  // Units
  // ==========================================================

  logic              w_mul_valid;
  muldiv_pkg::xlen_t w_mul_res;
  muldiv_pkg::tag_t  w_mul_tag;

  logic              w_div_ready;
  logic              w_div_valid;
  muldiv_pkg::xlen_t w_div_res;
  muldiv_pkg::tag_t  w_div_tag;

  mul_step_pipe u_mul (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (i_valid & w_is_mul),
    .i_op      (i_op),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .i_tag     (i_tag),
    .o_valid   (w_mul_valid),
    .o_res     (w_mul_res),
    .o_tag     (w_mul_tag)
  );

  div_unit u_div (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_valid      (i_valid & w_is_div),
    .i_req        (w_div_req),
    .o_ready      (w_div_ready),
    .i_kill_valid (i_br_kill_valid),
    .i_kill_mask  (i_br_kill_mask),
    .i_flush      (i_flush),
    .i_resp_ready (~w_mul_valid),   // Multiply owns the port when valid
    .o_valid      (w_div_valid),
    .o_res        (w_div_res),
    .o_tag        (w_div_tag)
  );

  // ==========================================================
  // Response
  // ==========================================================

  assign o_stall = ~w_div_ready;

  assign o_valid = w_mul_valid | w_div_valid;
  assign o_res   = w_mul_valid ? w_mul_res : w_div_res;
  assign o_tag   = w_mul_valid ? w_mul_tag : w_div_tag;

endmodule

`default_nettype wire

/* test/muldiv_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_settings.svh"

module muldiv_pipe_tb;

  parameter string TRACE_FILE = "test/muldiv_trace.txt";

  localparam int MAX_LINES = 128;

  logic                   i_clk;
  logic                   i_reset_n;
  logic                   i_valid;
  muldiv_pkg::op_t        i_op;
  muldiv_pkg::xlen_t      i_rs1;
  muldiv_pkg::xlen_t      i_rs2;
  muldiv_pkg::tag_t       i_tag;
  muldiv_pkg::br_mask_t   i_br_mask;
  logic                   i_br_kill_valid;
  muldiv_pkg::br_mask_t   i_br_kill_mask;
  logic                   i_flush;
  logic                   o_stall;
  logic                   o_valid;
  muldiv_pkg::xlen_t      o_res;
  muldiv_pkg::tag_t       o_tag;

  muldiv_pipe UUT (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_valid         (i_valid),
    .i_op            (i_op),
    .i_rs1           (i_rs1),
    .i_rs2           (i_rs2),
    .i_tag           (i_tag),
    .i_br_mask       (i_br_mask),
    .i_br_kill_valid (i_br_kill_valid),
    .i_br_kill_mask  (i_br_kill_mask),
    .i_flush         (i_flush),
    .o_stall         (o_stall),
    .o_valid         (o_valid),
    .o_res           (o_res),
    .o_tag           (o_tag)
  );

  // ==========================================================
  // Trace storage and scoreboard
  // ==========================================================

  int                n_lines = 0;
  int                t_grp   [MAX_LINES];
  int                t_op    [MAX_LINES];
  muldiv_pkg::xlen_t t_rs1   [MAX_LINES];
  muldiv_pkg::xlen_t t_rs2   [MAX_LINES];
  muldiv_pkg::tag_t  t_tag   [MAX_LINES];
  logic [3:0]        t_brm   [MAX_LINES];
  int                t_kk    [MAX_LINES];   // 0 none, 1 branch kill, 2 flush
  int                t_kd    [MAX_LINES];
  logic [3:0]        t_km    [MAX_LINES];
  int                t_back  [MAX_LINES];
  muldiv_pkg::xlen_t t_exp   [MAX_LINES];

  muldiv_pkg::tag_t  exp_tag [$];
  muldiv_pkg::xlen_t exp_res [$];
  int                exp_cyc [$];   // -1 when latency is free

  int               cyc      = 0;
  int               n_checks = 0;
  int               n_errors = 0;
  logic             div_watch = 1'b0;
  muldiv_pkg::tag_t div_tag;

  always #4 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cyc <= cyc + 1;
  end

  function automatic string group_name(input int g);
    case (g)
      1: return "mul low word";
      2: return "mulh forms";
      3: return "back-to-back muls";
      4: return "divides";
      5: return "divide squash";
      6: return "mul priority over div";
      default: return "misc";
    endcase
  endfunction

  // Divide by zero and signed overflow skip the iteration
  function automatic logic quick_divide(input int i);
    logic signed_op;
    signed_op = (t_op[i] == 5) || (t_op[i] == 7);
    return (t_rs2[i] == '0) ||
           (signed_op && t_rs1[i] == (muldiv_pkg::xlen_t'(1) << (`XLEN - 1)) &&
            t_rs2[i] == '1);
  endfunction

  // First cycle from the given one that no multiply result holds
  function automatic int free_cycle(input int first);
    int   c;
    logic taken;
    c     = first;
    taken = 1'b1;
    while (taken) begin
      taken = 1'b0;
      for (int k = 0; k < exp_cyc.size(); k++) begin
        if (exp_cyc[k] == c) taken = 1'b1;
      end
      if (taken) c++;
    end
    return c;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    n_errors++;
  endtask

  task automatic load_trace();
    int    fd;
    int    cnt;
    string line;
    int    grp_v;
    int    op_v;
    int    kk_v;
    int    kd_v;
    int    back_v;
    logic [31:0] rs1_v;
    logic [31:0] rs2_v;
    logic [31:0] rnid_v;
    logic [31:0] idx_v;
    logic [31:0] brm_v;
    logic [31:0] km_v;
    logic [31:0] exp_v;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the trace file %s", TRACE_FILE);
      return;
    end
    while (!$feof(fd) && n_lines < MAX_LINES) begin
      line = "";
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line.getc(0) == "#") continue;
      cnt = $sscanf(line, "%d %d %h %h %h %h %h %d %d %h %d %h", grp_v, op_v, rs1_v,
                    rs2_v, rnid_v, idx_v, brm_v, kk_v, kd_v, km_v, back_v, exp_v);
      if (cnt != 12) continue;
      t_grp[n_lines]  = grp_v;
      t_op[n_lines]   = op_v;
      t_rs1[n_lines]  = rs1_v;
      t_rs2[n_lines]  = rs2_v;
      t_tag[n_lines]  = {rnid_v[`RNID_W-1:0], idx_v[`RV_ENTRY_SIZE-1:0]};
      t_brm[n_lines]  = brm_v[3:0];
      t_kk[n_lines]   = kk_v;
      t_kd[n_lines]   = kd_v;
      t_km[n_lines]   = km_v[3:0];
      t_back[n_lines] = back_v;
      t_exp[n_lines]  = exp_v;
      n_lines++;
    end
    $fclose(fd);
  endtask

  // Waits until every expected result has come back
  task automatic drain_results();
    while (exp_tag.size() != 0 || div_watch) begin
      @(negedge i_clk);
    end
    repeat (3) @(negedge i_clk);
  endtask

  task automatic issue_line(input int i, input int next_back);
    logic squashed;
    int   due;
    squashed = (t_kk[i] == 2) || (t_kk[i] == 1 && (t_km[i] & t_brm[i]) != 0);
    @(negedge i_clk);
    while (o_stall) @(negedge i_clk);
    @(posedge i_clk);
    i_valid   <= 1'b1;
    i_op      <= muldiv_pkg::op_t'(t_op[i]);
    i_rs1     <= t_rs1[i];
    i_rs2     <= t_rs2[i];
    i_tag     <= t_tag[i];
    i_br_mask <= t_brm[i];
    if (!(t_op[i] >= 5 && squashed)) begin
      if (t_op[i] < 5) begin
        due = cyc + 5;   // 4 stages after sampling edge
      end else if (quick_divide(i)) begin
        due = free_cycle(cyc + 2);   // Special case waits only behind multiplies
      end else begin
        due = -1;
      end
      exp_tag.push_back(t_tag[i]);
      exp_res.push_back(t_exp[i]);
      exp_cyc.push_back(due);
    end
    if (t_op[i] >= 5) begin
      @(posedge i_clk);
      i_valid   <= 1'b0;
      div_tag   = t_tag[i];
      div_watch = 1'b1;
      if (t_kk[i] != 0) begin
        repeat (t_kd[i] - 1) @(posedge i_clk);
        if (t_kk[i] == 2) begin
          i_flush <= 1'b1;
        end else begin
          i_br_kill_valid <= 1'b1;
          i_br_kill_mask  <= t_km[i];
        end
        if (squashed) div_watch = 1'b0;
        @(posedge i_clk);
        i_flush         <= 1'b0;
        i_br_kill_valid <= 1'b0;
        i_br_kill_mask  <= '0;
        if (squashed) begin
          @(negedge i_clk);
          if (o_stall) begin
            report_mismatch("o_stall still high one cycle after the divide was squashed");
          end
        end
      end
    end else if (!next_back) begin
      @(posedge i_clk);
      i_valid <= 1'b0;
    end
  endtask

  // ==========================================================
  // Output monitor
  // ==========================================================

  always @(negedge i_clk) begin : output_monitor
    int hit;
    if (i_reset_n) begin
      if (div_watch && !o_stall) begin
        report_mismatch("o_stall fell before the divide result appeared");
        div_watch = 1'b0;
      end
      if (o_valid) begin
        hit = -1;
        for (int k = 0; k < exp_tag.size(); k++) begin
          if (exp_tag[k] == o_tag) hit = k;
        end
        if (hit < 0) begin
          $display("Unexpected result at %0t with tag %h and value %h", $time, o_tag, o_res);
          n_errors++;
        end else begin
          n_checks++;
          if (o_res != exp_res[hit]) begin
            report_mismatch($sformatf("tag %h result %h, expected %h",
                                      o_tag, o_res, exp_res[hit]));
          end
          if (exp_cyc[hit] >= 0 && exp_cyc[hit] != cyc) begin
            report_mismatch($sformatf("tag %h arrived in cycle %0d, expected %0d",
                                      o_tag, cyc, exp_cyc[hit]));
          end
          if (div_watch && o_tag == div_tag) div_watch = 1'b0;
          exp_tag.delete(hit);
          exp_res.delete(hit);
          exp_cyc.delete(hit);
        end
      end
    end
  end

  // ==========================================================
  // Main sequence
  // ==========================================================

  initial begin : main_sequence
    int gap;
    int grp_err;
    void'($urandom(32'h6fc2));
    i_clk           = 1'b0;
    i_reset_n       = 1'b0;
    i_valid         = 1'b0;
    i_op            = muldiv_pkg::OP_NONE;
    i_rs1           = '0;
    i_rs2           = '0;
    i_tag           = '0;
    i_br_mask       = '0;
    i_br_kill_valid = 1'b0;
    i_br_kill_mask  = '0;
    i_flush         = 1'b0;
    load_trace();
    if (n_lines == 0) begin
      $display("No operations were read from the trace");
      $display("TESTBENCH FAILED");
      $finish;
    end else begin
      repeat (2) @(posedge i_clk);
      i_reset_n <= 1'b1;
      grp_err = 0;
      for (int i = 0; i < n_lines; i++) begin
        if (i > 0 && t_grp[i] != t_grp[i-1]) begin
          drain_results();
          $display("group %0d (%s) done, %0d errors", t_grp[i-1], group_name(t_grp[i-1]),
                   n_errors - grp_err);
          grp_err = n_errors;
        end
        if (!t_back[i]) begin
          gap = $urandom % 4;
          repeat (gap) @(posedge i_clk);
        end
        issue_line(i, (i + 1 < n_lines) ? t_back[i+1] : 0);
      end
      drain_results();
      $display("group %0d (%s) done, %0d errors", t_grp[n_lines-1],
               group_name(t_grp[n_lines-1]), n_errors - grp_err);
      $display("results checked: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end
  end

  initial begin : watchdog
    wait (n_lines > 0);
    #(n_lines * (`XLEN + 10) * 8 + 200);
    $display("Timeout, the run did not finish in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* test/muldiv_trace.txt */
# grp op rs1 rs2 rnid idx br_mask kill(0 none,1 kill,2 flush) delay kill_mask back expect
# op: 1 MUL 2 MULH 3 MULHU 4 MULHSU 5 DIV 6 DIVU 7 REM 8 REMU; hex: rs1 rs2 rnid idx masks expect
1 1 00000007 00000006 01 01 0 0 0 0 0 0000002a
1 1 ffffffff 00000005 02 02 0 0 0 0 0 fffffffb
1 1 fffffff0 00000010 03 04 0 0 0 0 0 ffffff00
1 1 00010000 00010000 04 08 0 0 0 0 0 00000000
1 1 7fffffff 00000003 05 10 0 0 0 0 0 7ffffffd
2 2 ffffffff ffffffff 06 20 0 0 0 0 0 00000000
2 2 80000000 80000000 07 40 0 0 0 0 0 40000000
2 2 fffffff0 00000010 08 80 0 0 0 0 0 ffffffff
2 3 ffffffff ffffffff 09 01 0 0 0 0 0 fffffffe
2 3 80000000 00000004 0a 02 0 0 0 0 0 00000002
2 4 ffffffff ffffffff 0b 04 0 0 0 0 0 ffffffff
2 4 00000002 80000000 0c 08 0 0 0 0 0 00000001
2 4 80000000 ffffffff 0d 10 0 0 0 0 0 80000000
3 1 00000003 00000004 10 01 0 0 0 0 0 0000000c
3 1 00000100 00000100 11 02 0 0 0 0 1 00010000
3 1 fffffffe 00000003 12 04 0 0 0 0 1 fffffffa
3 1 0000ffff 0000ffff 13 08 0 0 0 0 1 fffe0001
4 5 00000014 fffffffa 14 01 1 0 0 0 0 fffffffd
4 5 ffffffec 00000006 15 02 1 0 0 0 0 fffffffd
4 7 ffffffec 00000006 16 04 1 0 0 0 0 fffffffe
4 7 00000014 fffffffa 17 08 1 0 0 0 0 00000002
4 6 ffffffff 00000010 18 10 1 0 0 0 0 0fffffff
4 8 ffffffff 00000010 19 20 1 0 0 0 0 0000000f
4 5 00001234 00000000 1a 40 1 0 0 0 0 ffffffff
4 7 00001234 00000000 1b 80 1 0 0 0 0 00001234
4 6 00000005 00000000 1c 01 1 0 0 0 0 ffffffff
4 8 00000005 00000000 1d 02 1 0 0 0 0 00000005
4 5 80000000 ffffffff 1e 04 1 0 0 0 0 80000000
4 7 80000000 ffffffff 1f 08 1 0 0 0 0 00000000
4 6 00000064 00000007 20 10 1 0 0 0 0 0000000e
5 5 00000064 00000007 21 01 2 1 6 2 0 00000000
5 5 00000064 00000007 22 02 2 2 10 0 0 00000000
5 6 00000064 00000007 23 04 1 1 8 4 0 0000000e
5 1 00000005 00000005 24 08 0 0 0 0 0 00000019
6 1 00000002 00000003 25 01 0 0 0 0 0 00000006
6 1 00000004 00000005 26 02 0 0 0 0 1 00000014
6 1 00000006 00000007 27 04 0 0 0 0 1 0000002a
6 6 00000009 00000000 28 08 1 0 0 0 1 ffffffff
6 1 00000003 00000003 29 10 0 0 0 0 0 00000009
6 1 00000008 00000008 2a 20 0 0 0 0 1 00000040
6 8 00000009 00000000 2b 40 1 0 0 0 1 00000009

/* filelist.f */
+incdir+design
design/muldiv_pkg.sv
design/mul_step_pipe.sv
design/div_unit.sv
design/muldiv_pipe.sv
test/muldiv_pipe_tb.sv

/* Makefile */
# Verilator build for the multiply/divide pipe

TOP      ?= muldiv_pipe_tb
TRACE    ?= test/muldiv_trace.txt
LOG      ?= sim.log
OBJ_DIR  ?= obj_dir
FILELIST ?= filelist.f
VERILATOR ?= verilator
VFLAGS   ?= --binary --timing -Wno-fatal

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) design/*.sv design/*.svh test/*.sv
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) '-GTRACE_FILE="$(TRACE)"'

run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@! grep -q "TESTBENCH FAILED" $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
